// ==== Makefile ====
# Verilator build and run of the execute stage testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing -j 0 -f build.f --top-module execute_tb
	./obj_dir/Vexecute_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "No result in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
verilog/exec_pkg.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/seq_multiplier.sv
verilog/seq_divider.sv
verilog/execute_stage.sv
verification/clock_gen.sv
verification/execute_sva.sv
verification/execute_tb.sv

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic bus,
  output logic rst
);

  // 10 ns period
  initial begin
    bus = 1'b0;
    forever #5 bus = ~bus;
  end

  // Reset held for 8 rising edges
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge bus);
    rst <= 1'b0;
  end

endmodule : clock_gen

`default_nettype wire

// ==== verification/execute_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_sva #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  input wire logic                       bus,
  input wire logic                       rst,
  input wire logic                       hold,
  input wire logic                       stall,
  input wire logic [DATA_W-1:0]          ex_mem_res,
  input wire logic [DATA_W-1:0]          ex_mem_store_data,
  input wire logic [exec_pkg::REG_W-1:0] ex_mem_rd,
  input wire logic                       ex_mem_regwrite,
  input wire logic                       ex_mem_memread,
  input wire logic                       ex_mem_memwrite,
  input wire logic                       ex_mem_comp_res,
  input wire logic [DATA_W-1:0]          ex_mem_pc
);

  // Consecutive stalled cycles
  int stall_run;

  always_ff @(posedge bus) begin
    if (rst || !stall) begin
      stall_run <= 0;
    end else begin
      stall_run <= stall_run + 1;
    end
  end

  // Stage comes out of reset ready
  a_reset_stall: assert property (@(posedge bus) $fell(rst) |-> !stall)
    else $error("stall high right after reset");

  // Back-pressure freezes the whole register
  a_hold_stable: assert property (@(posedge bus) disable iff (rst)
    hold |=> ($stable(ex_mem_res) && $stable(ex_mem_store_data) && $stable(ex_mem_rd) &&
              $stable(ex_mem_regwrite) && $stable(ex_mem_memread) &&
              $stable(ex_mem_memwrite) && $stable(ex_mem_comp_res) && $stable(ex_mem_pc)))
    else $error("EX/MEM output changed under hold");

  a_stall_bound: assert property (@(posedge bus) disable iff (rst) stall_run <= DATA_W + 3)
    else $error("stall too long");

endmodule : execute_sva

`default_nettype wire

// ==== verification/execute_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

  localparam int W  = exec_pkg::XLEN;
  localparam int SH = $clog2(W);

  typedef struct packed {
    logic [W-1:0] res;
    logic [W-1:0] store;
    logic [W-1:0] pc;
    logic [4:0]   rd;
    logic         rw;
    logic         mr;
    logic         mw;
    logic         comp;
  } exp_t;

  logic bus;
  logic rst;
  logic hold;
  exec_pkg::unit_e   id_unit;
  exec_pkg::alu_op_e id_alu_op;
  exec_pkg::cmp_op_e id_cmp_op;
  exec_pkg::mul_op_e id_mul_op;
  exec_pkg::div_op_e id_div_op;
  logic         id_compare;
  logic         id_alusrc;
  logic [W-1:0] id_pc;
  logic [4:0]   id_rs1;
  logic [4:0]   id_rs2;
  logic [4:0]   id_rd;
  logic [W-1:0] id_rs1_data;
  logic [W-1:0] id_rs2_data;
  logic [W-1:0] id_imm;
  logic         id_regwrite;
  logic         id_memread;
  logic         id_memwrite;
  logic         wb_regwrite;
  logic [4:0]   wb_rd;
  logic [W-1:0] wb_res;
  logic         stall;
  logic [W-1:0] ex_mem_res;
  logic [W-1:0] ex_mem_store_data;
  logic [4:0]   ex_mem_rd;
  logic         ex_mem_regwrite;
  logic         ex_mem_memread;
  logic         ex_mem_memwrite;
  logic         ex_mem_comp_res;
  logic [W-1:0] ex_mem_pc;

  integer seed;
  // Expected captures and a shadow of the last one for forwarding
  exp_t   exp_q[$];
  exp_t   prev;
  int     n;

  clock_gen u_clock_gen (.bus(bus), .rst(rst));

  execute_stage #(.DATA_W(W)) u_execute_stage (.*);

  bind execute_stage execute_sva #(.DATA_W(DATA_W)) u_execute_sva (
    .bus(bus), .rst(rst), .hold(hold), .stall(stall), .ex_mem_res(ex_mem_res),
    .ex_mem_store_data(ex_mem_store_data), .ex_mem_rd(ex_mem_rd),
    .ex_mem_regwrite(ex_mem_regwrite), .ex_mem_memread(ex_mem_memread),
    .ex_mem_memwrite(ex_mem_memwrite), .ex_mem_comp_res(ex_mem_comp_res),
    .ex_mem_pc(ex_mem_pc)
  );

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while %s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // EX/MEM non-loads win over write-back and x0 never forwards
  function automatic logic [W-1:0] fwd(input logic [4:0] rs, input logic [W-1:0] d);
    if (prev.rw && !prev.mr && rs != 5'd0 && prev.rd == rs) begin
      return prev.res;
    end
    if (wb_regwrite && rs != 5'd0 && wb_rd == rs) begin
      return wb_res;
    end
    return d;
  endfunction

  function automatic logic cmp_model(input exec_pkg::cmp_op_e op, input logic [W-1:0] a,
                                     input logic [W-1:0] b);
    case (op)
      exec_pkg::CMP_EQ:  return a == b;
      exec_pkg::CMP_NE:  return a != b;
      exec_pkg::CMP_LT:  return $signed(a) < $signed(b);
      exec_pkg::CMP_GE:  return $signed(a) >= $signed(b);
      exec_pkg::CMP_LTU: return a < b;
      exec_pkg::CMP_GEU: return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic logic [W-1:0] exec_model(
    input exec_pkg::unit_e unit, input exec_pkg::alu_op_e aop, input exec_pkg::mul_op_e mop,
    input exec_pkg::div_op_e dop, input logic [W-1:0] a, input logic [W-1:0] b,
    input logic [W-1:0] pc
  );
    logic [2*W-1:0] ea;
    logic [2*W-1:0] eb;
    logic [2*W-1:0] p;
    logic           sgn;
    logic           ovf;
    if (unit == exec_pkg::UNIT_MUL) begin
      // Extending by form makes the product mod 2^(2W) exact
      ea = (mop != exec_pkg::MUL_MULHU) ? {{W{a[W-1]}}, a} : {{W{1'b0}}, a};
      eb = (mop == exec_pkg::MUL_MUL || mop == exec_pkg::MUL_MULH) ?
           {{W{b[W-1]}}, b} : {{W{1'b0}}, b};
      p = ea * eb;
      return (mop == exec_pkg::MUL_MUL) ? p[W-1:0] : p[2*W-1:W];
    end
    if (unit == exec_pkg::UNIT_DIV) begin
      sgn = (dop == exec_pkg::DIV_DIV || dop == exec_pkg::DIV_REM);
      ovf = sgn && a == {1'b1, {(W-1){1'b0}}} && b == '1;
      case (dop)
        exec_pkg::DIV_DIV:  return (b == '0) ? '1 : (ovf ? a : W'($signed(a) / $signed(b)));
        exec_pkg::DIV_DIVU: return (b == '0) ? '1 : a / b;
        exec_pkg::DIV_REM:  return (b == '0) ? a : (ovf ? '0 : W'($signed(a) % $signed(b)));
        default:            return (b == '0) ? a : a % b;
      endcase
    end
    case (aop)
      exec_pkg::ALU_ADD:   return a + b;
      exec_pkg::ALU_SUB:   return a - b;
      exec_pkg::ALU_AND:   return a & b;
      exec_pkg::ALU_OR:    return a | b;
      exec_pkg::ALU_XOR:   return a ^ b;
      exec_pkg::ALU_SLL:   return a << b[SH-1:0];
      exec_pkg::ALU_SRL:   return a >> b[SH-1:0];
      exec_pkg::ALU_SRA:   return W'($signed(a) >>> b[SH-1:0]);
      exec_pkg::ALU_SLT:   return {{(W-1){1'b0}}, $signed(a) < $signed(b)};
      exec_pkg::ALU_SLTU:  return {{(W-1){1'b0}}, a < b};
      exec_pkg::ALU_LUI:   return b;
      exec_pkg::ALU_AUIPC: return pc + b;
      exec_pkg::ALU_LINK:  return pc + W'(4);
      default:             return '0;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // New random ALU instruction on the falling edge with a small register range for hazards
  task automatic random_instr();
    logic [31:0] r;
    logic [2:0]  k;
    @(negedge bus);
    r = rand32();
    k = r[6:4];
    id_unit     = exec_pkg::UNIT_ALU;
    id_alu_op   = exec_pkg::alu_op_e'(r[3:0] % 4'd13);
    id_cmp_op   = exec_pkg::cmp_op_e'((k[2:1] == 2'b01) ? {1'b1, k[1:0]} : k);
    id_mul_op   = exec_pkg::mul_op_e'(r[8:7]);
    id_div_op   = exec_pkg::div_op_e'(r[10:9]);
    id_compare  = r[11];
    id_alusrc   = r[12];
    id_rs1      = {2'b00, r[15:13]};
    id_rs2      = {2'b00, r[18:16]};
    id_rd       = {2'b00, r[21:19]};
    id_regwrite = r[22];
    id_memread  = (r[24:23] == 2'b00);
    id_memwrite = r[25] && (r[24:23] != 2'b00);
    wb_regwrite = r[26];
    wb_rd       = {2'b00, r[29:27]};
    r = rand32();
    id_pc       = {r[31:2], 2'b00};
    id_rs1_data = rand32();
    id_rs2_data = rand32();
    id_imm      = rand32();
    wb_res      = rand32();
  endtask

  // Hold window is counted in cycles from issue and the task waits for capture
  task automatic run_instr(input int hold_at, input int hold_len);
    logic [W-1:0] a;
    logic [W-1:0] rs2f;
    logic [W-1:0] b;
    exp_t         e;
    int           cyc;
    logic         go;
    a    = fwd(id_rs1, id_rs1_data);
    rs2f = fwd(id_rs2, id_rs2_data);
    b    = id_alusrc ? id_imm : rs2f;
    e.res   = exec_model(id_unit, id_alu_op, id_mul_op, id_div_op, a, b, id_pc);
    e.comp  = cmp_model(id_cmp_op, a, b);
    e.rw    = id_regwrite && (!id_compare || e.comp);
    e.store = rs2f;
    e.pc    = id_pc;
    e.rd    = id_rd;
    e.mr    = id_memread;
    e.mw    = id_memwrite;
    cyc = 0;
    go  = 1'b0;
    while (!go) begin
      hold = (cyc >= hold_at) && (cyc < hold_at + hold_len);
      #1;
      if (!hold && !stall) begin
        go = 1'b1;
      end else begin
        @(negedge bus);
        cyc = cyc + 1;
        if (cyc > 200) timeout_fail("waiting for stall to fall");
      end
    end
    @(posedge bus);
    exp_q.push_back(e);
    prev = e;
  endtask

  // Compare one capture per falling edge
  always @(negedge bus) begin : compare_proc
    exp_t e;
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_value("ex_mem_res", ex_mem_res, e.res);
      check_value("ex_mem_store_data", ex_mem_store_data, e.store);
      check_value("ex_mem_pc", ex_mem_pc, e.pc);
      check_value("ex_mem_rd", W'(ex_mem_rd), W'(e.rd));
      check_value("ex_mem_regwrite", W'(ex_mem_regwrite), W'(e.rw));
      check_value("ex_mem_memread", W'(ex_mem_memread), W'(e.mr));
      check_value("ex_mem_memwrite", W'(ex_mem_memwrite), W'(e.mw));
      check_value("ex_mem_comp_res", W'(ex_mem_comp_res), W'(e.comp));
    end
  end

  initial begin
    seed = 32'h7e7c;
    hold = 1'b0;
    id_unit = exec_pkg::UNIT_ALU;
    id_alu_op = exec_pkg::ALU_ADD;
    id_cmp_op = exec_pkg::CMP_EQ;
    id_mul_op = exec_pkg::MUL_MUL;
    id_div_op = exec_pkg::DIV_DIV;
    {id_compare, id_alusrc, id_regwrite, id_memread, id_memwrite} = '0;
    {id_pc, id_rs1_data, id_rs2_data, id_imm, wb_res} = '0;
    {id_rs1, id_rs2, id_rd, wb_rd} = '0;
    wb_regwrite = 1'b0;
    prev = '0;
    n = 0;
    @(negedge bus);
    while (rst) begin
      @(negedge bus);
      n = n + 1;
      if (n > 50) timeout_fail("waiting for reset release");
    end
    // Everything cleared by reset
    check_value("stall", W'(stall), W'(0));
    check_value("ex_mem_res", ex_mem_res, W'(0));
    check_value("ex_mem_store_data", ex_mem_store_data, W'(0));
    check_value("ex_mem_pc", ex_mem_pc, W'(0));
    check_value("ex_mem_rd", W'(ex_mem_rd), W'(0));
    check_value("ex_mem_regwrite", W'(ex_mem_regwrite), W'(0));
    check_value("ex_mem_memread", W'(ex_mem_memread), W'(0));
    check_value("ex_mem_memwrite", W'(ex_mem_memwrite), W'(0));
    check_value("ex_mem_comp_res", W'(ex_mem_comp_res), W'(0));

    // ALU, compare and forwarding mix
    repeat (300) begin
      random_instr();
      run_instr(0, 0);
    end
    // Multiply and divide in every form
    repeat (80) begin
      random_instr();
      id_unit = (rand32() & 1) ? exec_pkg::UNIT_MUL : exec_pkg::UNIT_DIV;
      run_instr(0, 0);
    end
    // Divide by zero in all four forms then min / -1 for div and rem
    for (int i = 0; i < 6; i++) begin
      random_instr();
      id_unit     = exec_pkg::UNIT_DIV;
      id_div_op   = exec_pkg::div_op_e'(i[1:0]);
      id_alusrc   = 1'b0;
      wb_regwrite = 1'b0;
      id_rs1      = 5'd0;
      id_rs2      = 5'd0;
      id_rs2_data = (i < 4) ? '0 : '1;
      if (i >= 4) id_rs1_data = {1'b1, {(W-1){1'b0}}};
      if (i == 5) id_div_op = exec_pkg::DIV_REM;
      run_instr(0, 0);
    end
    // Hold on an ALU op and then across the end of long ops
    repeat (4) begin
      random_instr();
      run_instr(0, 3);
      random_instr();
      id_unit = exec_pkg::UNIT_DIV;
      run_instr(5, 45);
      random_instr();
      id_unit = exec_pkg::UNIT_MUL;
      run_instr(3, 4);
      random_instr();
      run_instr(0, 0);
    end

    @(negedge bus);
    #1;
    if (exp_q.size() == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Captures left unchecked at end of run");
      $display("RESULT: FAIL");
      $fatal(1);
    end
  end

endmodule : execute_tb

`default_nettype wire

// ==== verilog/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // Datapath and register address widths
  localparam int XLEN  = 32;
  localparam int REG_W = 5;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    // Pass b through
    ALU_LUI   = 4'd10,
    ALU_AUIPC = 4'd11,
    // Return address for jal and jalr
    ALU_LINK  = 4'd12
  } alu_op_e;

  // Branch compare codes match the B-type funct3
  typedef enum logic [2:0] {
    CMP_EQ  = 3'b000,
    CMP_NE  = 3'b001,
    CMP_LT  = 3'b100,
    CMP_GE  = 3'b101,
    CMP_LTU = 3'b110,
    CMP_GEU = 3'b111
  } cmp_op_e;

  // Result source
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_e;

  // Low two bits of the RV32M funct3
  typedef enum logic [1:0] {
    MUL_MUL    = 2'd0,
    MUL_MULH   = 2'd1,
    MUL_MULHSU = 2'd2,
    MUL_MULHU  = 2'd3
  } mul_op_e;

  typedef enum logic [1:0] {
    DIV_DIV  = 2'd0,
    DIV_DIVU = 2'd1,
    DIV_REM  = 2'd2,
    DIV_REMU = 2'd3
  } div_op_e;

endpackage : exec_pkg

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  input  wire logic                       bus,
  input  wire logic                       rst,
  // Memory stage back-pressure
  input  wire logic                       hold,
  // Decode register
  input  wire exec_pkg::unit_e            id_unit,
  input  wire exec_pkg::alu_op_e          id_alu_op,
  input  wire exec_pkg::cmp_op_e          id_cmp_op,
  input  wire exec_pkg::mul_op_e          id_mul_op,
  input  wire exec_pkg::div_op_e          id_div_op,
  input  wire logic                       id_compare,
  input  wire logic                       id_alusrc,
  input  wire logic [DATA_W-1:0]          id_pc,
  input  wire logic [exec_pkg::REG_W-1:0] id_rs1,
  input  wire logic [exec_pkg::REG_W-1:0] id_rs2,
  input  wire logic [exec_pkg::REG_W-1:0] id_rd,
  input  wire logic [DATA_W-1:0]          id_rs1_data,
  input  wire logic [DATA_W-1:0]          id_rs2_data,
  input  wire logic [DATA_W-1:0]          id_imm,
  input  wire logic                       id_regwrite,
  input  wire logic                       id_memread,
  input  wire logic                       id_memwrite,
  // Write-back port
  input  wire logic                       wb_regwrite,
  input  wire logic [exec_pkg::REG_W-1:0] wb_rd,
  input  wire logic [DATA_W-1:0]          wb_res,
  output logic                            stall,
  // EX/MEM register
  output logic      [DATA_W-1:0]          ex_mem_res,
  output logic      [DATA_W-1:0]          ex_mem_store_data,
  output logic      [exec_pkg::REG_W-1:0] ex_mem_rd,
  output logic                            ex_mem_regwrite,
  output logic                            ex_mem_memread,
  output logic                            ex_mem_memwrite,
  output logic                            ex_mem_comp_res,
  output logic      [DATA_W-1:0]          ex_mem_pc
);

  logic [DATA_W-1:0] op_a;
  logic [DATA_W-1:0] op_b;
  logic [DATA_W-1:0] store_data;
  logic [DATA_W-1:0] alu_res;
  logic              comp_res;
  logic [DATA_W-1:0] mul_res;
  logic [DATA_W-1:0] div_res;
  logic              mul_done;
  logic              div_done;
  logic              is_mul;
  logic              is_div;
  logic              unit_done;
  logic              result_ready;
  logic              start;
  logic              busy;
  logic              done_flag;
  logic              capture;
  logic [DATA_W-1:0] unit_res;

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////

  operand_forward #(.DATA_W(DATA_W)) u_operand_forward (
    .ex_mem_regwrite (ex_mem_regwrite),
    .ex_mem_memread  (ex_mem_memread),
    .ex_mem_rd       (ex_mem_rd),
    .ex_mem_res      (ex_mem_res),
    .wb_regwrite     (wb_regwrite),
    .wb_rd           (wb_rd),
    .wb_res          (wb_res),
    .id_rs1          (id_rs1),
    .id_rs2          (id_rs2),
    .id_rs1_data     (id_rs1_data),
    .id_rs2_data     (id_rs2_data),
    .id_imm          (id_imm),
    .id_alusrc       (id_alusrc),
    .op_a            (op_a),
    .op_b            (op_b),
    .store_data      (store_data)
  );

  int_alu #(.DATA_W(DATA_W)) u_int_alu (
    .a        (op_a),
    .b        (op_b),
    .pc       (id_pc),
    .alu_op   (id_alu_op),
    .cmp_op   (id_cmp_op),
    .res      (alu_res),
    .comp_res (comp_res)
  );

  // Each unit sees the shared start only for its own ops
  seq_multiplier #(.DATA_W(DATA_W)) u_seq_multiplier (
    .bus    (bus),
    .rst    (rst),
    .start  (start && is_mul),
    .mul_op (id_mul_op),
    .a      (op_a),
    .b      (op_b),
    .done   (mul_done),
    .res    (mul_res)
  );

  seq_divider #(.DATA_W(DATA_W)) u_seq_divider (
    .bus    (bus),
    .rst    (rst),
    .start  (start && is_div),
    .div_op (id_div_op),
    .a      (op_a),
    .b      (op_b),
    .done   (div_done),
    .res    (div_res)
  );

  //////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////

  assign is_mul    = (id_unit == exec_pkg::UNIT_MUL);
  assign is_div    = (id_unit == exec_pkg::UNIT_DIV);
  assign unit_done = (is_mul && mul_done) || (is_div && div_done);

  // Result is usable in the done cycle or any later cycle under hold
  assign result_ready = unit_done || done_flag;

  // Start pulses on the first cycle only and never while a result is pending
  assign start = (is_mul || is_div) && !busy && !result_ready && !hold;

  // Decode waits until the long op has a result
  assign stall = (is_mul || is_div) && !result_ready;

  assign capture = !hold && !stall;

  always_ff @(posedge bus) begin
    if (rst) begin
      busy      <= 1'b0;
      done_flag <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (unit_done) begin
        busy <= 1'b0;
      end
      // Keep the finished result across hold
      if (unit_done && hold) begin
        done_flag <= 1'b1;
      end else if (!hold) begin
        done_flag <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // EX/MEM register
  //////////////////////////////////////////////////

  always_comb begin
    unique case (id_unit)
      exec_pkg::UNIT_MUL: unit_res = mul_res;
      exec_pkg::UNIT_DIV: unit_res = div_res;
      default:            unit_res = alu_res;
    endcase
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      ex_mem_res        <= '0;
      ex_mem_store_data <= '0;
      ex_mem_rd         <= '0;
      ex_mem_regwrite   <= 1'b0;
      ex_mem_memread    <= 1'b0;
      ex_mem_memwrite   <= 1'b0;
      ex_mem_comp_res   <= 1'b0;
      ex_mem_pc         <= '0;
    end else if (capture) begin
      ex_mem_res        <= unit_res;
      ex_mem_store_data <= store_data;
      ex_mem_rd         <= id_rd;
      // Compare ops write rd only when the condition holds
      ex_mem_regwrite   <= id_regwrite && (!id_compare || comp_res);
      ex_mem_memread    <= id_memread;
      ex_mem_memwrite   <= id_memwrite;
      ex_mem_comp_res   <= comp_res;
      ex_mem_pc         <= id_pc;
    end
  end

endmodule : execute_stage

`default_nettype wire

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_alu #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  input  wire logic [DATA_W-1:0]    a,
  input  wire logic [DATA_W-1:0]    b,
  input  wire logic [DATA_W-1:0]    pc,
  input  wire exec_pkg::alu_op_e    alu_op,
  input  wire exec_pkg::cmp_op_e    cmp_op,
  output logic      [DATA_W-1:0]    res,
  output logic                      comp_res
);

  // Shift amount width
  localparam int SH_W = $clog2(DATA_W);

  logic [SH_W-1:0] shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;

  assign shamt = b[SH_W-1:0];

  // Shared by slt and the comparator
  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////

  always_comb begin
    unique case (alu_op)
      exec_pkg::ALU_ADD:   res = a + b;
      exec_pkg::ALU_SUB:   res = a - b;
      exec_pkg::ALU_AND:   res = a & b;
      exec_pkg::ALU_OR:    res = a | b;
      exec_pkg::ALU_XOR:   res = a ^ b;
      exec_pkg::ALU_SLL:   res = a << shamt;
      exec_pkg::ALU_SRL:   res = a >> shamt;
      // Arithmetic shift keeps the sign
      exec_pkg::ALU_SRA:   res = $signed(a) >>> shamt;
      exec_pkg::ALU_SLT:   res = {{(DATA_W-1){1'b0}}, lt_s};
      exec_pkg::ALU_SLTU:  res = {{(DATA_W-1){1'b0}}, lt_u};
      // Immediate already shifted by decode
      exec_pkg::ALU_LUI:   res = b;
      exec_pkg::ALU_AUIPC: res = pc + b;
      exec_pkg::ALU_LINK:  res = pc + DATA_W'(4);
      default:             res = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Branch compare
  //////////////////////////////////////////////////

  always_comb begin
    unique case (cmp_op)
      exec_pkg::CMP_EQ:  comp_res = eq;
      exec_pkg::CMP_NE:  comp_res = !eq;
      exec_pkg::CMP_LT:  comp_res = lt_s;
      exec_pkg::CMP_GE:  comp_res = !lt_s;
      exec_pkg::CMP_LTU: comp_res = lt_u;
      exec_pkg::CMP_GEU: comp_res = !lt_u;
      // Unused codes never take the branch
      default:           comp_res = 1'b0;
    endcase
  end

endmodule : int_alu

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  // EX/MEM register of this stage
  input  wire logic                       ex_mem_regwrite,
  input  wire logic                       ex_mem_memread,
  input  wire logic [exec_pkg::REG_W-1:0] ex_mem_rd,
  input  wire logic [DATA_W-1:0]          ex_mem_res,
  // Retiring instruction
  input  wire logic                       wb_regwrite,
  input  wire logic [exec_pkg::REG_W-1:0] wb_rd,
  input  wire logic [DATA_W-1:0]          wb_res,
  // Decode values
  input  wire logic [exec_pkg::REG_W-1:0] id_rs1,
  input  wire logic [exec_pkg::REG_W-1:0] id_rs2,
  input  wire logic [DATA_W-1:0]          id_rs1_data,
  input  wire logic [DATA_W-1:0]          id_rs2_data,
  input  wire logic [DATA_W-1:0]          id_imm,
  input  wire logic                       id_alusrc,
  output logic      [DATA_W-1:0]          op_a,
  output logic      [DATA_W-1:0]          op_b,
  output logic      [DATA_W-1:0]          store_data
);

  logic [DATA_W-1:0] rs2_fwd;

  // Priority select for one source register
  function automatic logic [DATA_W-1:0] pick(
    input logic [exec_pkg::REG_W-1:0] rs,
    input logic [DATA_W-1:0]          rs_data
  );
    logic ex_hit;
    logic wb_hit;
    // Load data is not known yet in EX/MEM, so only non-loads forward from there
    ex_hit = ex_mem_regwrite && !ex_mem_memread && (ex_mem_rd != '0) && (ex_mem_rd == rs);
    wb_hit = wb_regwrite && (wb_rd != '0) && (wb_rd == rs);
    if (ex_hit) begin
      return ex_mem_res;
    end else if (wb_hit) begin
      return wb_res;
    end
    return rs_data;
  endfunction

  // Youngest producer wins
  always_comb begin
    op_a    = pick(id_rs1, id_rs1_data);
    rs2_fwd = pick(id_rs2, id_rs2_data);
  end

  // Immediate forms replace rs2 on the ALU side only
  assign op_b = id_alusrc ? id_imm : rs2_fwd;

  // Stores always write the register value
  assign store_data = rs2_fwd;

endmodule : operand_forward

`default_nettype wire

// ==== verilog/seq_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_divider #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  input  wire logic                bus,
  input  wire logic                rst,
  input  wire logic                start,
  input  wire exec_pkg::div_op_e   div_op,
  input  wire logic [DATA_W-1:0]   a,
  input  wire logic [DATA_W-1:0]   b,
  output logic                     done,
  output logic      [DATA_W-1:0]   res
);

  localparam int CNT_W = $clog2(DATA_W + 1);

  logic              running;
  logic              fixup;
  logic [CNT_W-1:0]  count;
  logic [DATA_W-1:0] divisor;
  logic [DATA_W-1:0] quo;
  logic [DATA_W-1:0] rem;
  logic              q_neg;
  logic              r_neg;
  logic              b_zero;
  logic              want_rem;
  logic              is_signed;
  logic              a_neg;
  logic              b_neg;
  logic [DATA_W:0]   shifted;
  logic [DATA_W:0]   trial;
  logic [DATA_W-1:0] q_fix;
  logic [DATA_W-1:0] r_fix;

  assign is_signed = (div_op == exec_pkg::DIV_DIV) || (div_op == exec_pkg::DIV_REM);
  assign a_neg     = is_signed && a[DATA_W-1];
  assign b_neg     = is_signed && b[DATA_W-1];

  // Bring down the next dividend bit and try the subtract
  assign shifted = {rem, quo[DATA_W-1]};
  assign trial   = shifted - {1'b0, divisor};

  // Remainder takes the dividend sign
  // min / -1 works out here, as the quotient magnitude negates back to a
  assign q_fix = b_zero ? '1 : (q_neg ? -quo : quo);
  assign r_fix = r_neg ? -rem : rem;

  always_ff @(posedge bus) begin
    if (rst) begin
      running <= 1'b0;
      fixup   <= 1'b0;
      count   <= '0;
      done    <= 1'b0;
    end else begin
      done  <= 1'b0;
      fixup <= 1'b0;
      if (running) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1)) begin
          running <= 1'b0;
          fixup   <= 1'b1;
        end
      end else if (fixup) begin
        done <= 1'b1;
      end else if (start) begin
        running <= 1'b1;
        count   <= CNT_W'(DATA_W);
      end
    end
  end

  // Datapath
  always_ff @(posedge bus) begin
    if (running) begin
      // Restore on a negative trial
      if (!trial[DATA_W]) begin
        rem <= trial[DATA_W-1:0];
        quo <= {quo[DATA_W-2:0], 1'b1};
      end else begin
        rem <= shifted[DATA_W-1:0];
        quo <= {quo[DATA_W-2:0], 1'b0};
      end
    end else if (fixup) begin
      res <= want_rem ? r_fix : q_fix;
    end else if (start) begin
      divisor  <= b_neg ? -b : b;
      quo      <= a_neg ? -a : a;
      rem      <= '0;
      q_neg    <= a_neg ^ b_neg;
      r_neg    <= a_neg;
      b_zero   <= (b == '0);
      want_rem <= (div_op == exec_pkg::DIV_REM) || (div_op == exec_pkg::DIV_REMU);
    end
  end

endmodule : seq_divider

`default_nettype wire

// ==== verilog/seq_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_multiplier #(
  parameter int DATA_W = exec_pkg::XLEN
) (
  input  wire logic                bus,
  input  wire logic                rst,
  input  wire logic                start,
  input  wire exec_pkg::mul_op_e   mul_op,
  input  wire logic [DATA_W-1:0]   a,
  input  wire logic [DATA_W-1:0]   b,
  output logic                     done,
  output logic      [DATA_W-1:0]   res
);

  // Wide enough to hold DATA_W itself
  localparam int CNT_W = $clog2(DATA_W + 1);

  logic                running;
  logic [CNT_W-1:0]    count;
  logic [DATA_W-1:0]   mcand;
  logic [DATA_W-1:0]   prod_hi;
  logic [DATA_W-1:0]   prod_lo;
  logic                negate;
  logic                take_high;
  logic                a_neg;
  logic                b_neg;
  logic [DATA_W:0]     sum;
  logic [2*DATA_W-1:0] prod_fix;

  // Operand signs depend on the form and mulhu is unsigned on both sides
  assign a_neg = (mul_op != exec_pkg::MUL_MULHU) && a[DATA_W-1];
  assign b_neg = ((mul_op == exec_pkg::MUL_MUL) || (mul_op == exec_pkg::MUL_MULH)) &&
                 b[DATA_W-1];

  // Add the multiplicand when the current multiplier bit is set
  assign sum = {1'b0, prod_hi} + (prod_lo[0] ? {1'b0, mcand} : '0);

  always_ff @(posedge bus) begin
    if (rst) begin
      running <= 1'b0;
      count   <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (running) begin
        count <= count - 1'b1;
        if (count == CNT_W'(1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end else if (start) begin
        running <= 1'b1;
        count   <= CNT_W'(DATA_W);
      end
    end
  end

  // Product and magnitudes
  always_ff @(posedge bus) begin
    if (running) begin
      {prod_hi, prod_lo} <= {sum, prod_lo[DATA_W-1:1]};
    end else if (start) begin
      mcand     <= a_neg ? -a : a;
      prod_hi   <= '0;
      prod_lo   <= b_neg ? -b : b;
      negate    <= a_neg ^ b_neg;
      take_high <= (mul_op != exec_pkg::MUL_MUL);
    end
  end

  // Full-width sign fix stays steady once the loop ends
  assign prod_fix = negate ? -{prod_hi, prod_lo} : {prod_hi, prod_lo};
  assign res      = take_high ? prod_fix[2*DATA_W-1:DATA_W] : prod_fix[DATA_W-1:0];

endmodule : seq_multiplier

`default_nettype wire
